//--- src/riscv_ctrl_pkg.sv
`default_nettype none

package riscv_ctrl_pkg;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jalr   = 7'b1100111,
    op_jal    = 7'b1101111,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_system = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_t;

  // ALU class picked in decode, refined by funct fields in execute
  typedef enum logic [1:0] {
    alu_op_add    = 2'b00,
    alu_op_branch = 2'b01,
    alu_op_reg    = 2'b10,
    alu_op_imm    = 2'b11
  } alu_op_t;

  // branch funct3
  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_t;

  typedef enum logic [1:0] {
    wb_alu = 2'b00,
    wb_mem = 2'b01,
    wb_pc4 = 2'b10,
    wb_csr = 2'b11
  } wb_sel_t;

  typedef enum logic [1:0] {
    fwd_none = 2'b00,
    fwd_mem  = 2'b01,
    fwd_wb   = 2'b10
  } fwd_src_t;

  typedef struct packed {
    logic    reg_write;
    logic    mem_write;
    logic    branch;
    logic    alu_src;
    logic    jump;
    logic    lui;
    logic    auipc;
    logic    jal;
    logic    csr_type;
    logic    invalid_inst;
    alu_op_t alu_op;
    wb_sel_t mem_to_reg;
  } decoded_ctrl_t;

  // register addresses and write info reported by the datapath
  typedef struct packed {
    logic [4:0] rs1_id;
    logic [4:0] rs2_id;
    logic [4:0] rs1_exe;
    logic [4:0] rs2_exe;
    logic [4:0] rs2_mem;
    logic [4:0] rd_exe;
    logic [4:0] rd_mem;
    logic [4:0] rd_wb;
    logic       reg_write_mem;
    logic       reg_write_wb;
    wb_sel_t    mem_to_reg_exe;
  } pipe_regs_t;

  typedef struct packed {
    logic     fwd_rd1_id;
    logic     fwd_rd2_id;
    logic     fwd_rd2_mem;
    fwd_src_t fwd_rd1_exe;
    fwd_src_t fwd_rd2_exe;
  } fwd_ctrl_t;

  typedef struct packed {
    logic if_id_clr;
    logic id_exe_clr;
    logic exe_mem_clr;
    logic mem_wb_clr;
    logic if_id_en;
    logic id_exe_en;
    logic exe_mem_en;
    logic mem_wb_en;
    logic pc_en;
  } pipe_ctrl_t;

endpackage

`default_nettype wire

//--- src/decode_control.sv
`default_nettype none

module decode_control (
  input  logic [6:0]                    opcode,
  output riscv_ctrl_pkg::decoded_ctrl_t ctrl,
  output logic                          use_rs1,
  output logic                          use_rs2
);

  always_comb begin
    ctrl = '0;
    case (riscv_ctrl_pkg::opcode_t'(opcode))
      riscv_ctrl_pkg::op_load: begin
        ctrl.reg_write  = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.alu_op     = riscv_ctrl_pkg::alu_op_add;
        ctrl.mem_to_reg = riscv_ctrl_pkg::wb_mem;
      end
      riscv_ctrl_pkg::op_store: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = riscv_ctrl_pkg::alu_op_add;
      end
      riscv_ctrl_pkg::op_branch: begin
        ctrl.branch = 1'b1;
        ctrl.alu_op = riscv_ctrl_pkg::alu_op_branch;
      end
      // link register gets pc + 4 for both jumps
      riscv_ctrl_pkg::op_jalr: begin
        ctrl.reg_write  = 1'b1;
        ctrl.jump       = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.mem_to_reg = riscv_ctrl_pkg::wb_pc4;
      end
      riscv_ctrl_pkg::op_jal: begin
        ctrl.reg_write  = 1'b1;
        ctrl.jump       = 1'b1;
        ctrl.jal        = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.mem_to_reg = riscv_ctrl_pkg::wb_pc4;
      end
      riscv_ctrl_pkg::op_imm: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = riscv_ctrl_pkg::alu_op_imm;
      end
      riscv_ctrl_pkg::op_reg: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = riscv_ctrl_pkg::alu_op_reg;
      end
      riscv_ctrl_pkg::op_lui: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.lui       = 1'b1;
      end
      riscv_ctrl_pkg::op_auipc: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.auipc     = 1'b1;
      end
      // csr access is only decoded and its data returns on the csr writeback path
      riscv_ctrl_pkg::op_system: begin
        ctrl.reg_write  = 1'b1;
        ctrl.csr_type   = 1'b1;
        ctrl.mem_to_reg = riscv_ctrl_pkg::wb_csr;
      end
      default: ctrl.invalid_inst = 1'b1;
    endcase
  end

  // source registers read by the decode instruction
  assign use_rs1 = ~(ctrl.lui | ctrl.auipc | ctrl.jal);
  assign use_rs2 = (ctrl.alu_op == riscv_ctrl_pkg::alu_op_reg) | ctrl.branch | ctrl.mem_write;

endmodule

`default_nettype wire

//--- src/alu_control.sv
`default_nettype none

module alu_control (
  input  riscv_ctrl_pkg::alu_op_t alu_op,
  input  logic [2:0]              fun3,
  input  logic [6:0]              fun7,
  output riscv_ctrl_pkg::alu_t    alu_ctrl
);

  always_comb begin
    alu_ctrl = riscv_ctrl_pkg::alu_add;
    case (alu_op)
      riscv_ctrl_pkg::alu_op_add: alu_ctrl = riscv_ctrl_pkg::alu_add;
      // compare chosen so that the zero flag resolves the branch
      riscv_ctrl_pkg::alu_op_branch: begin
        case (fun3)
          riscv_ctrl_pkg::beq,  riscv_ctrl_pkg::bne:  alu_ctrl = riscv_ctrl_pkg::alu_sub;
          riscv_ctrl_pkg::blt,  riscv_ctrl_pkg::bge:  alu_ctrl = riscv_ctrl_pkg::alu_slt;
          riscv_ctrl_pkg::bltu, riscv_ctrl_pkg::bgeu: alu_ctrl = riscv_ctrl_pkg::alu_sltu;
          default:                                    alu_ctrl = riscv_ctrl_pkg::alu_add;
        endcase
      end
      default: begin
        case (fun3)
          3'b000: begin
            // addi has no sub form, funct7 there is immediate bits
            if (alu_op == riscv_ctrl_pkg::alu_op_reg && fun7[5]) begin
              alu_ctrl = riscv_ctrl_pkg::alu_sub;
            end else begin
              alu_ctrl = riscv_ctrl_pkg::alu_add;
            end
          end
          3'b001: alu_ctrl = riscv_ctrl_pkg::alu_sll;
          3'b010: alu_ctrl = riscv_ctrl_pkg::alu_slt;
          3'b011: alu_ctrl = riscv_ctrl_pkg::alu_sltu;
          3'b100: alu_ctrl = riscv_ctrl_pkg::alu_xor;
          3'b101: alu_ctrl = fun7[5] ? riscv_ctrl_pkg::alu_sra : riscv_ctrl_pkg::alu_srl;
          3'b110: alu_ctrl = riscv_ctrl_pkg::alu_or;
          default: alu_ctrl = riscv_ctrl_pkg::alu_and;
        endcase
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/branch_controller.sv
`default_nettype none

module branch_controller (
  input  riscv_ctrl_pkg::branch_t fun3,
  input  logic                    branch,
  input  logic                    jump,
  input  logic                    zero,
  output logic                    pc_sel
);

  logic taken;

  // zero reflects sub for beq/bne and slt/sltu for the ordered compares
  always_comb begin
    case (fun3)
      riscv_ctrl_pkg::beq,
      riscv_ctrl_pkg::bge,
      riscv_ctrl_pkg::bgeu: taken = zero;
      riscv_ctrl_pkg::bne,
      riscv_ctrl_pkg::blt,
      riscv_ctrl_pkg::bltu: taken = ~zero;
      default:              taken = 1'b0;
    endcase
  end

  assign pc_sel = jump | (branch & taken);

endmodule

`default_nettype wire

//--- src/forwarding_unit.sv
`default_nettype none

module forwarding_unit (
  input  riscv_ctrl_pkg::pipe_regs_t pipe_regs,
  output riscv_ctrl_pkg::fwd_ctrl_t  fwd
);

  logic mem_ok;
  logic wb_ok;

  // x0 is never a bypass source
  assign mem_ok = pipe_regs.reg_write_mem && (pipe_regs.rd_mem != 5'd0);
  assign wb_ok  = pipe_regs.reg_write_wb && (pipe_regs.rd_wb != 5'd0);

  always_comb begin
    // newest producer wins, so memory beats writeback
    if (mem_ok && pipe_regs.rd_mem == pipe_regs.rs1_exe) begin
      fwd.fwd_rd1_exe = riscv_ctrl_pkg::fwd_mem;
    end else if (wb_ok && pipe_regs.rd_wb == pipe_regs.rs1_exe) begin
      fwd.fwd_rd1_exe = riscv_ctrl_pkg::fwd_wb;
    end else begin
      fwd.fwd_rd1_exe = riscv_ctrl_pkg::fwd_none;
    end

    if (mem_ok && pipe_regs.rd_mem == pipe_regs.rs2_exe) begin
      fwd.fwd_rd2_exe = riscv_ctrl_pkg::fwd_mem;
    end else if (wb_ok && pipe_regs.rd_wb == pipe_regs.rs2_exe) begin
      fwd.fwd_rd2_exe = riscv_ctrl_pkg::fwd_wb;
    end else begin
      fwd.fwd_rd2_exe = riscv_ctrl_pkg::fwd_none;
    end

    // decode operands and store data only see writeback
    fwd.fwd_rd1_id  = wb_ok && (pipe_regs.rd_wb == pipe_regs.rs1_id);
    fwd.fwd_rd2_id  = wb_ok && (pipe_regs.rd_wb == pipe_regs.rs2_id);
    fwd.fwd_rd2_mem = wb_ok && (pipe_regs.rd_wb == pipe_regs.rs2_mem);
  end

endmodule

`default_nettype wire

//--- src/hazard_handler.sv
`default_nettype none

module hazard_handler (
  input  riscv_ctrl_pkg::pipe_regs_t pipe_regs,
  input  logic                       use_rs1,
  input  logic                       use_rs2,
  output logic                       load_hazard
);

  logic late_result;
  logic rs1_hit;
  logic rs2_hit;

  // load and csr data are not ready until after memory
  assign late_result = (pipe_regs.mem_to_reg_exe == riscv_ctrl_pkg::wb_mem) ||
                       (pipe_regs.mem_to_reg_exe == riscv_ctrl_pkg::wb_csr);

  assign rs1_hit = use_rs1 && (pipe_regs.rd_exe == pipe_regs.rs1_id);
  assign rs2_hit = use_rs2 && (pipe_regs.rd_exe == pipe_regs.rs2_id);

  assign load_hazard = late_result && (pipe_regs.rd_exe != 5'd0) && (rs1_hit || rs2_hit);

endmodule

`default_nettype wire

//--- src/pipeline_controller.sv
`default_nettype none

module pipeline_controller (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       load_hazard,
  input  logic                       pc_sel,
  input  logic                       stall_pipl,
  output riscv_ctrl_pkg::pipe_ctrl_t pipe
);

  logic flush_pending;
  logic flush;

  assign flush = pc_sel | flush_pending;

  // remember a redirect that arrives while the pipe is frozen
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flush_pending <= 1'b0;
    end else if (stall_pipl) begin
      if (pc_sel) begin
        flush_pending <= 1'b1;
      end
    end else begin
      flush_pending <= 1'b0;
    end
  end

  always_comb begin
    pipe            = '0;
    pipe.if_id_en   = 1'b1;
    pipe.id_exe_en  = 1'b1;
    pipe.exe_mem_en = 1'b1;
    pipe.mem_wb_en  = 1'b1;
    pipe.pc_en      = 1'b1;

    if (stall_pipl) begin
      pipe.if_id_en   = 1'b0;
      pipe.id_exe_en  = 1'b0;
      pipe.exe_mem_en = 1'b0;
      pipe.mem_wb_en  = 1'b0;
      pipe.pc_en      = 1'b0;
    end else if (flush) begin
      // kill the three younger stages behind the redirect
      pipe.if_id_clr   = 1'b1;
      pipe.id_exe_clr  = 1'b1;
      pipe.exe_mem_clr = 1'b1;
    end else if (load_hazard) begin
      // hold fetch and decode, insert a bubble into execute
      pipe.pc_en      = 1'b0;
      pipe.if_id_en   = 1'b0;
      pipe.id_exe_clr = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/control_unit.sv
`default_nettype none

module control_unit (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [6:0]                    opcode_id,
  input  logic [2:0]                    fun3_exe,
  input  logic [6:0]                    fun7_exe,
  input  riscv_ctrl_pkg::alu_op_t       alu_op_exe,
  input  riscv_ctrl_pkg::branch_t       fun3_mem,
  input  logic                          branch_mem,
  input  logic                          jump_mem,
  input  logic                          zero_mem,
  input  riscv_ctrl_pkg::pipe_regs_t    pipe_regs,
  input  logic                          stall_pipl,
  output riscv_ctrl_pkg::decoded_ctrl_t ctrl_id,
  output riscv_ctrl_pkg::alu_t          alu_ctrl_exe,
  output logic                          pc_sel_mem,
  output riscv_ctrl_pkg::fwd_ctrl_t     fwd,
  output logic                          load_hazard,
  output riscv_ctrl_pkg::pipe_ctrl_t    pipe
);

  logic use_rs1_id;
  logic use_rs2_id;

  decode_control dec_ctrl_inst (
    .opcode  (opcode_id),
    .ctrl    (ctrl_id),
    .use_rs1 (use_rs1_id),
    .use_rs2 (use_rs2_id)
  );

  alu_control alu_ctrl_inst (
    .alu_op   (alu_op_exe),
    .fun3     (fun3_exe),
    .fun7     (fun7_exe),
    .alu_ctrl (alu_ctrl_exe)
  );

  branch_controller branch_ctrl_inst (
    .fun3   (fun3_mem),
    .branch (branch_mem),
    .jump   (jump_mem),
    .zero   (zero_mem),
    .pc_sel (pc_sel_mem)
  );

  forwarding_unit fwd_unit_inst (
    .pipe_regs (pipe_regs),
    .fwd       (fwd)
  );

  hazard_handler hazard_inst (
    .pipe_regs   (pipe_regs),
    .use_rs1     (use_rs1_id),
    .use_rs2     (use_rs2_id),
    .load_hazard (load_hazard)
  );

  pipeline_controller pipe_ctrl_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_hazard (load_hazard),
    .pc_sel      (pc_sel_mem),
    .stall_pipl  (stall_pipl),
    .pipe        (pipe)
  );

endmodule

`default_nettype wire

//--- verif/control_unit_tb.sv
`default_nettype none

module control_unit_tb;

  // clears in the upper four bits, then if_id/id_exe/exe_mem/mem_wb enables, then pc_en
  localparam riscv_ctrl_pkg::pipe_ctrl_t pipe_idle  = 9'b0000_11111;
  localparam riscv_ctrl_pkg::pipe_ctrl_t pipe_flush = 9'b1110_11111;
  localparam riscv_ctrl_pkg::pipe_ctrl_t pipe_bubble = 9'b0100_01110;

  logic                          clk;
  logic                          rst_n;
  logic [6:0]                    opcode_id;
  logic [2:0]                    fun3_exe;
  logic [6:0]                    fun7_exe;
  riscv_ctrl_pkg::alu_op_t       alu_op_exe;
  riscv_ctrl_pkg::branch_t       fun3_mem;
  logic                          branch_mem;
  logic                          jump_mem;
  logic                          zero_mem;
  riscv_ctrl_pkg::pipe_regs_t    pipe_regs;
  logic                          stall_pipl;
  riscv_ctrl_pkg::decoded_ctrl_t ctrl_id;
  riscv_ctrl_pkg::alu_t          alu_ctrl_exe;
  logic                          pc_sel_mem;
  riscv_ctrl_pkg::fwd_ctrl_t     fwd;
  logic                          load_hazard;
  riscv_ctrl_pkg::pipe_ctrl_t    pipe;

  logic [31:0] rng_state;
  // model copy of flush_pending
  logic        pending_q;
  logic        pending_d;
  int          checks;
  int          errors;
  int          tests;
  int          checks_at_start;
  int          errors_at_start;

  logic [6:0] listed_ops [10] = '{
    riscv_ctrl_pkg::op_load, riscv_ctrl_pkg::op_store, riscv_ctrl_pkg::op_branch,
    riscv_ctrl_pkg::op_jalr, riscv_ctrl_pkg::op_jal, riscv_ctrl_pkg::op_imm,
    riscv_ctrl_pkg::op_reg, riscv_ctrl_pkg::op_lui, riscv_ctrl_pkg::op_auipc,
    riscv_ctrl_pkg::op_system
  };

  control_unit uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .opcode_id    (opcode_id),
    .fun3_exe     (fun3_exe),
    .fun7_exe     (fun7_exe),
    .alu_op_exe   (alu_op_exe),
    .fun3_mem     (fun3_mem),
    .branch_mem   (branch_mem),
    .jump_mem     (jump_mem),
    .zero_mem     (zero_mem),
    .pipe_regs    (pipe_regs),
    .stall_pipl   (stall_pipl),
    .ctrl_id      (ctrl_id),
    .alu_ctrl_exe (alu_ctrl_exe),
    .pc_sel_mem   (pc_sel_mem),
    .fwd          (fwd),
    .load_hazard  (load_hazard),
    .pipe         (pipe)
  );

  always #20 clk = ~clk;

  // lcg step returning the n most random top bits
  function automatic logic [31:0] rand_bits(input int n);
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state >> (32 - n);
  endfunction

  // flag bits in order reg_write mem_write branch alu_src jump lui auipc jal csr_type
  function automatic riscv_ctrl_pkg::decoded_ctrl_t make_ctrl(input logic [8:0] flags,
      input riscv_ctrl_pkg::alu_op_t op, input riscv_ctrl_pkg::wb_sel_t wb);
    return {flags, 1'b0, op, wb};
  endfunction

  function automatic riscv_ctrl_pkg::decoded_ctrl_t model_decode(input logic [6:0] opc);
    riscv_ctrl_pkg::decoded_ctrl_t c;
    c = '0;
    case (opc)
      riscv_ctrl_pkg::op_load:   c = make_ctrl(9'b100100000, riscv_ctrl_pkg::alu_op_add,
                                               riscv_ctrl_pkg::wb_mem);
      riscv_ctrl_pkg::op_store:  c = make_ctrl(9'b010100000, riscv_ctrl_pkg::alu_op_add,
                                               riscv_ctrl_pkg::wb_alu);
      riscv_ctrl_pkg::op_branch: c = make_ctrl(9'b001000000, riscv_ctrl_pkg::alu_op_branch,
                                               riscv_ctrl_pkg::wb_alu);
      riscv_ctrl_pkg::op_jalr:   c = make_ctrl(9'b100110000, riscv_ctrl_pkg::alu_op_add,
                                               riscv_ctrl_pkg::wb_pc4);
      riscv_ctrl_pkg::op_jal:    c = make_ctrl(9'b100110010, riscv_ctrl_pkg::alu_op_add,
                                               riscv_ctrl_pkg::wb_pc4);
      riscv_ctrl_pkg::op_imm:    c = make_ctrl(9'b100100000, riscv_ctrl_pkg::alu_op_imm,
                                               riscv_ctrl_pkg::wb_alu);
      riscv_ctrl_pkg::op_reg:    c = make_ctrl(9'b100000000, riscv_ctrl_pkg::alu_op_reg,
                                               riscv_ctrl_pkg::wb_alu);
      riscv_ctrl_pkg::op_lui:    c = make_ctrl(9'b100101000, riscv_ctrl_pkg::alu_op_add,
                                               riscv_ctrl_pkg::wb_alu);
      riscv_ctrl_pkg::op_auipc:  c = make_ctrl(9'b100100100, riscv_ctrl_pkg::alu_op_add,
                                               riscv_ctrl_pkg::wb_alu);
      riscv_ctrl_pkg::op_system: c = make_ctrl(9'b100000001, riscv_ctrl_pkg::alu_op_add,
                                               riscv_ctrl_pkg::wb_csr);
      default:                   c.invalid_inst = 1'b1;
    endcase
    return c;
  endfunction

  function automatic riscv_ctrl_pkg::alu_t model_alu(input riscv_ctrl_pkg::alu_op_t op,
      input logic [2:0] f3, input logic [6:0] f7);
    if (op == riscv_ctrl_pkg::alu_op_add) begin
      return riscv_ctrl_pkg::alu_add;
    end
    if (op == riscv_ctrl_pkg::alu_op_branch) begin
      // funct3[2:1] groups eq/ne, signed and unsigned compares
      case (f3[2:1])
        2'b00:   return riscv_ctrl_pkg::alu_sub;
        2'b10:   return riscv_ctrl_pkg::alu_slt;
        2'b11:   return riscv_ctrl_pkg::alu_sltu;
        default: return riscv_ctrl_pkg::alu_add;
      endcase
    end
    case (f3)
      3'd0: return (op == riscv_ctrl_pkg::alu_op_reg && f7[5]) ? riscv_ctrl_pkg::alu_sub
                                                                : riscv_ctrl_pkg::alu_add;
      3'd1: return riscv_ctrl_pkg::alu_sll;
      3'd2: return riscv_ctrl_pkg::alu_slt;
      3'd3: return riscv_ctrl_pkg::alu_sltu;
      3'd4: return riscv_ctrl_pkg::alu_xor;
      3'd5: return f7[5] ? riscv_ctrl_pkg::alu_sra : riscv_ctrl_pkg::alu_srl;
      3'd6: return riscv_ctrl_pkg::alu_or;
      default: return riscv_ctrl_pkg::alu_and;
    endcase
  endfunction

  function automatic logic model_branch(input logic [2:0] f3, input logic br,
                                        input logic jmp, input logic zero);
    logic cond;
    case (f3)
      3'b000, 3'b101, 3'b111: cond = zero;
      3'b001, 3'b100, 3'b110: cond = !zero;
      default:                cond = 1'b0;
    endcase
    return jmp || (br && cond);
  endfunction

  function automatic riscv_ctrl_pkg::fwd_src_t pick_src(input logic mem_hit, input logic wb_hit);
    if (mem_hit) begin
      return riscv_ctrl_pkg::fwd_mem;
    end
    return wb_hit ? riscv_ctrl_pkg::fwd_wb : riscv_ctrl_pkg::fwd_none;
  endfunction

  function automatic riscv_ctrl_pkg::fwd_ctrl_t model_fwd(input riscv_ctrl_pkg::pipe_regs_t p);
    riscv_ctrl_pkg::fwd_ctrl_t f;
    logic mem_v;
    logic wb_v;
    mem_v = p.reg_write_mem && p.rd_mem != 5'd0;
    wb_v = p.reg_write_wb && p.rd_wb != 5'd0;
    f.fwd_rd1_exe = pick_src(mem_v && p.rd_mem == p.rs1_exe, wb_v && p.rd_wb == p.rs1_exe);
    f.fwd_rd2_exe = pick_src(mem_v && p.rd_mem == p.rs2_exe, wb_v && p.rd_wb == p.rs2_exe);
    f.fwd_rd1_id = wb_v && p.rd_wb == p.rs1_id;
    f.fwd_rd2_id = wb_v && p.rd_wb == p.rs2_id;
    f.fwd_rd2_mem = wb_v && p.rd_wb == p.rs2_mem;
    return f;
  endfunction

  function automatic logic model_hazard(input logic [6:0] opc,
                                        input riscv_ctrl_pkg::pipe_regs_t p);
    logic rs1_used;
    logic rs2_used;
    logic late;
    rs1_used = !(opc == riscv_ctrl_pkg::op_lui || opc == riscv_ctrl_pkg::op_auipc ||
                 opc == riscv_ctrl_pkg::op_jal);
    rs2_used = opc == riscv_ctrl_pkg::op_reg || opc == riscv_ctrl_pkg::op_branch ||
               opc == riscv_ctrl_pkg::op_store;
    late = p.mem_to_reg_exe == riscv_ctrl_pkg::wb_mem || p.mem_to_reg_exe == riscv_ctrl_pkg::wb_csr;
    return late && p.rd_exe != 5'd0 &&
           ((rs1_used && p.rd_exe == p.rs1_id) || (rs2_used && p.rd_exe == p.rs2_id));
  endfunction

  function automatic riscv_ctrl_pkg::pipe_ctrl_t model_pipe(input logic stall,
      input logic redirect, input logic hazard, input logic pending);
    if (stall) begin
      return '0;
    end
    if (redirect || pending) begin
      return pipe_flush;
    end
    return hazard ? pipe_bubble : pipe_idle;
  endfunction

  task automatic check_ctrl(input riscv_ctrl_pkg::decoded_ctrl_t got,
                            input riscv_ctrl_pkg::decoded_ctrl_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_alu(input riscv_ctrl_pkg::alu_t got, input riscv_ctrl_pkg::alu_t exp,
                           input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_fwd(input riscv_ctrl_pkg::fwd_ctrl_t got,
                           input riscv_ctrl_pkg::fwd_ctrl_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_pipe(input riscv_ctrl_pkg::pipe_ctrl_t got,
                            input riscv_ctrl_pkg::pipe_ctrl_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_outputs();
    logic exp_pc_sel;
    logic exp_hazard;
    exp_pc_sel = model_branch(fun3_mem, branch_mem, jump_mem, zero_mem);
    exp_hazard = model_hazard(opcode_id, pipe_regs);
    check_ctrl(ctrl_id, model_decode(opcode_id), "ctrl_id");
    check_alu(alu_ctrl_exe, model_alu(alu_op_exe, fun3_exe, fun7_exe), "alu_ctrl_exe");
    check_bit(pc_sel_mem, exp_pc_sel, "pc_sel_mem");
    check_fwd(fwd, model_fwd(pipe_regs), "fwd");
    check_bit(load_hazard, exp_hazard, "load_hazard");
    check_pipe(pipe, model_pipe(stall_pipl, exp_pc_sel, exp_hazard, pending_q), "pipe");
    // value flush_pending takes at the coming edge
    if (!rst_n || !stall_pipl) begin
      pending_d = 1'b0;
    end else begin
      pending_d = pending_q | exp_pc_sel;
    end
  endtask

  task automatic drive_idle();
    opcode_id = 7'd0;
    fun3_exe = 3'd0;
    fun7_exe = 7'd0;
    alu_op_exe = riscv_ctrl_pkg::alu_op_add;
    fun3_mem = riscv_ctrl_pkg::beq;
    branch_mem = 1'b0;
    jump_mem = 1'b0;
    zero_mem = 1'b0;
    pipe_regs = '0;
    stall_pipl = 1'b0;
  endtask

  // stall and redirect modes are 0 for off, 1 for random and 2 for forced on
  task automatic drive_random(input logic [6:0] opc, input int addr_bits,
                              input int stall_mode, input int redirect_mode);
    opcode_id = opc;
    fun3_exe = 3'(rand_bits(3));
    fun7_exe = 7'(rand_bits(7));
    alu_op_exe = riscv_ctrl_pkg::alu_op_t'(2'(rand_bits(2)));
    fun3_mem = riscv_ctrl_pkg::branch_t'(3'(rand_bits(3)));
    zero_mem = rand_bits(1);
    branch_mem = (redirect_mode == 1) ? rand_bits(1) : 1'b0;
    jump_mem = (redirect_mode == 2) || (redirect_mode == 1 && rand_bits(3) == 0);
    stall_pipl = (stall_mode == 2) || (stall_mode == 1 && rand_bits(1) == 1);
    pipe_regs.rs1_id = 5'(rand_bits(addr_bits));
    pipe_regs.rs2_id = 5'(rand_bits(addr_bits));
    pipe_regs.rs1_exe = 5'(rand_bits(addr_bits));
    pipe_regs.rs2_exe = 5'(rand_bits(addr_bits));
    pipe_regs.rs2_mem = 5'(rand_bits(addr_bits));
    pipe_regs.rd_exe = 5'(rand_bits(addr_bits));
    pipe_regs.rd_mem = 5'(rand_bits(addr_bits));
    pipe_regs.rd_wb = 5'(rand_bits(addr_bits));
    pipe_regs.reg_write_mem = rand_bits(1);
    pipe_regs.reg_write_wb = rand_bits(1);
    pipe_regs.mem_to_reg_exe = riscv_ctrl_pkg::wb_sel_t'(2'(rand_bits(2)));
  endtask

  task automatic run_cycle(input logic [6:0] opc, input int addr_bits,
                           input int stall_mode, input int redirect_mode);
    @(posedge clk);
    pending_q = pending_d;
    #5;
    drive_random(opc, addr_bits, stall_mode, redirect_mode);
    #30;
    check_outputs();
  endtask

  task automatic run_idle_cycle(input logic rst_level);
    @(posedge clk);
    pending_q = pending_d;
    #5;
    rst_n = rst_level;
    drive_idle();
    #30;
    check_outputs();
  endtask

  task automatic start_test();
    checks_at_start = checks;
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s: %0d checks, %0d errors", name, checks - checks_at_start,
             errors - errors_at_start);
  endtask

  // reset for five edges, then wait for the pipe to come up idle
  task automatic reset_dut(output logic ok);
    int waited;
    for (int i = 0; i < 5; i++) begin
      run_idle_cycle(i == 4);
    end
    waited = 0;
    ok = (pipe === pipe_idle);
    while (!ok && waited < 20) begin
      run_idle_cycle(1'b1);
      ok = (pipe === pipe_idle);
      waited++;
    end
  endtask

  initial begin
    logic ok;
    clk = 1'b0;
    rst_n = 1'b0;
    rng_state = 32'h041d488f;
    pending_q = 1'b0;
    pending_d = 1'b0;
    checks = 0;
    errors = 0;
    tests = 0;
    drive_idle();

    start_test();
    reset_dut(ok);
    if (!ok) begin
      $display("timeout: pipeline enables did not come up after reset");
      $display("SIMULATION FAILED");
    end else begin
      end_test("reset");

      start_test();
      for (int i = 0; i < 10; i++) begin
        run_cycle(listed_ops[i], 3, 0, 1);
      end
      for (int i = 0; i < 300; i++) begin
        run_cycle(7'(rand_bits(7)), 3, 0, 1);
      end
      end_test("decode");

      start_test();
      for (int i = 0; i < 200; i++) begin
        run_cycle(listed_ops[rand_bits(4) % 10], 3, 0, 1);
      end
      end_test("alu_control");

      start_test();
      for (int i = 0; i < 200; i++) begin
        run_cycle(listed_ops[rand_bits(4) % 10], 3, 0, 1);
      end
      end_test("branch");

      start_test();
      for (int i = 0; i < 300; i++) begin
        run_cycle(listed_ops[rand_bits(4) % 10], 2, 0, 1);
      end
      end_test("forwarding");

      // no redirect, so every hazard shows up as a bubble
      start_test();
      for (int i = 0; i < 300; i++) begin
        run_cycle(listed_ops[rand_bits(4) % 10], 2, 0, 0);
      end
      end_test("load_use");

      start_test();
      for (int i = 0; i < 8; i++) begin
        run_cycle(listed_ops[rand_bits(4) % 10], 3, 2, 2);
        run_cycle(listed_ops[rand_bits(4) % 10], 3, 2, 0);
        run_cycle(listed_ops[rand_bits(4) % 10], 3, 0, 0);
      end
      for (int i = 0; i < 400; i++) begin
        run_cycle(listed_ops[rand_bits(4) % 10], 3, 1, 1);
      end
      end_test("flush_stall");

      $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0) begin
        $display("SIMULATION PASSED");
      end else begin
        $display("SIMULATION FAILED");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
src/riscv_ctrl_pkg.sv
src/decode_control.sv
src/alu_control.sv
src/branch_controller.sv
src/forwarding_unit.sv
src/hazard_handler.sv
src/pipeline_controller.sv
src/control_unit.sv
verif/control_unit_tb.sv

//--- Bender.yml
package:
  name: riscv_ctrl

sources:
  - src/riscv_ctrl_pkg.sv
  - src/decode_control.sv
  - src/alu_control.sv
  - src/branch_controller.sv
  - src/forwarding_unit.sv
  - src/hazard_handler.sv
  - src/pipeline_controller.sv
  - src/control_unit.sv
  - target: test
    files:
      - verif/control_unit_tb.sv
